/* project.f */
logic/tron_pkg.sv
logic/raster_if.sv
logic/raster_timing.sv
logic/frame_ram.sv
logic/bike_raster.sv
logic/pixel_combine.sv
logic/tron_video_top.sv
tb/tron_video_asserts.sv
tb/tron_video_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tron_video_tb -f project.f -o tron_video_sim
./obj_dir/tron_video_sim +verilator+error+limit+1000 2>&1 | tee sim.log
if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

/* tb/tron_video_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tron_video_tb import tron_pkg::*; ();

	localparam int H_ACTIVE = 32;
	localparam int V_ACTIVE = 16;
	localparam int H_TOTAL = 40;
	localparam int V_TOTAL = 20;
	localparam int DEPTH = (H_ACTIVE / 2) * V_ACTIVE;
	localparam int ADDR_W = $clog2(DEPTH);
	// reset plus eight frames for a run of about six
	localparam int TIMEOUT_CYCLES = 10 + 8 * H_TOTAL * V_TOTAL;
	// parking spot far outside the screen
	localparam logic [COORD_W-1:0] OFF_SCREEN = 10'd600;

	logic clk = 1'b0;
	logic reset;
	logic we;
	logic [ADDR_W-1:0] write_address;
	logic [WORD_W-1:0] write_data;
	logic [COORD_W-1:0] blue_x;
	logic [COORD_W-1:0] blue_y;
	dir_t blue_dir;
	logic [COORD_W-1:0] red_x;
	logic [COORD_W-1:0] red_y;
	dir_t red_dir;
	logic pixel_valid;
	logic [3:0] color_index;
	logic [COORD_W-1:0] pixel_x;
	logic [COORD_W-1:0] pixel_y;
	logic hsync;
	logic vsync;
	logic blocked_blue;
	logic blocked_red;

	// model of frame buffer, output position and flags
	logic [WORD_W-1:0] model_mem [DEPTH];
	logic [COORD_W-1:0] exp_x;
	logic [COORD_W-1:0] exp_y;
	logic rst_d1 = 1'b1;
	logic rst_d2 = 1'b1;
	logic exp_valid;
	color_t exp_color;
	logic blue_next;
	logic red_next;
	logic exp_blue_q;
	logic exp_red_q;
	logic check_pixels;
	logic [31:0] rng;
	int errors = 0;
	int cycles = 0;

	tron_video_top #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL)) uut (.clk(clk), .reset(reset), .we(we),
		.write_address(write_address), .write_data(write_data), .blue_x(blue_x),
		.blue_y(blue_y), .blue_dir(blue_dir), .red_x(red_x), .red_y(red_y),
		.red_dir(red_dir), .pixel_valid(pixel_valid), .color_index(color_index),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .hsync(hsync), .vsync(vsync),
		.blocked_blue(blocked_blue), .blocked_red(blocked_red));

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// box from the top-left corner with the long side along the heading
	function automatic logic in_box(input logic [COORD_W-1:0] px,
		input logic [COORD_W-1:0] py, input logic [COORD_W-1:0] bx,
		input logic [COORD_W-1:0] by, input dir_t dir);
		int w;
		int h;
		w = (dir == DIR_UP || dir == DIR_DOWN) ? int'(BIKE_WIDTH) : int'(BIKE_LEN);
		h = (dir == DIR_UP || dir == DIR_DOWN) ? int'(BIKE_LEN) : int'(BIKE_WIDTH);
		return int'(px) >= int'(bx) && int'(px) < int'(bx) + w &&
			int'(py) >= int'(by) && int'(py) < int'(by) + h;
	endfunction

	// pixel just past the front edge
	function automatic logic nose_hit(input logic [COORD_W-1:0] px,
		input logic [COORD_W-1:0] py, input logic [COORD_W-1:0] bx,
		input logic [COORD_W-1:0] by, input dir_t dir);
		int nx;
		int ny;
		nx = (dir == DIR_LEFT) ? int'(bx) - 1 : int'(bx) + int'(NOSE_SIDE);
		ny = (dir == DIR_UP) ? int'(by) - 1 : int'(by) + int'(NOSE_SIDE);
		if (dir == DIR_DOWN)
			ny = int'(by) + int'(BIKE_LEN);
		if (dir == DIR_RIGHT)
			nx = int'(bx) + int'(BIKE_LEN);
		return int'(px) == nx && int'(py) == ny;
	endfunction

	// even pixel in bits 3:0 and odd pixel in bits 11:8
	function automatic color_t bg_nibble(input logic [COORD_W-1:0] px,
		input logic [COORD_W-1:0] py);
		logic [WORD_W-1:0] word;
		word = model_mem[ADDR_W'(int'(py) * (H_ACTIVE / 2) + int'(px) / 2)];
		return px[0] ? word[11:8] : word[3:0];
	endfunction

	// mirror of every accepted write
	always @(posedge clk)
	begin
		if (we)
			model_mem[write_address] <= write_data;
	end

	// output position two cycles behind the raster which restarts at (0,0)
	always @(posedge clk)
	begin
		rst_d1 <= reset;
		rst_d2 <= rst_d1;
		if (rst_d2)
		begin
			exp_x <= '0;
			exp_y <= '0;
		end
		else if (exp_x == COORD_W'(H_TOTAL - 1))
		begin
			exp_x <= '0;
			exp_y <= (exp_y == COORD_W'(V_TOTAL - 1)) ? '0 : exp_y + 1'b1;
		end
		else
			exp_x <= exp_x + 1'b1;
	end

	always_comb
	begin
		// nothing valid while the pipeline fills after reset
		exp_valid = !rst_d2 && (exp_x < COORD_W'(H_ACTIVE)) && (exp_y < COORD_W'(V_ACTIVE));
		// blue on top of red on top of the background
		if (in_box(pixel_x, pixel_y, blue_x, blue_y, blue_dir))
			exp_color = COLOR_BLUE;
		else if (in_box(pixel_x, pixel_y, red_x, red_y, red_dir))
			exp_color = COLOR_RED;
		else
			exp_color = bg_nibble(pixel_x, pixel_y);
		// cleared at (0,0) unless a nose hit on that same pixel sets it
		blue_next = (pixel_x == '0 && pixel_y == '0) ? 1'b0 : exp_blue_q;
		red_next = (pixel_x == '0 && pixel_y == '0) ? 1'b0 : exp_red_q;
		if (exp_valid && bg_nibble(pixel_x, pixel_y) != COLOR_EMPTY)
		begin
			if (nose_hit(pixel_x, pixel_y, blue_x, blue_y, blue_dir))
				blue_next = 1'b1;
			if (nose_hit(pixel_x, pixel_y, red_x, red_y, red_dir))
				red_next = 1'b1;
		end
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			exp_blue_q <= 1'b0;
			exp_red_q <= 1'b0;
		end
		else
		begin
			exp_blue_q <= blue_next;
			exp_red_q <= red_next;
		end
	end

	// outputs sampled mid-cycle
	x_check: assert property (@(negedge clk) disable iff (reset) pixel_x == exp_x)
		else
		begin
			errors++;
			$display("FAIL pixel_x expected %h got %h", exp_x, pixel_x);
		end
	y_check: assert property (@(negedge clk) disable iff (reset) pixel_y == exp_y)
		else
		begin
			errors++;
			$display("FAIL pixel_y expected %h got %h", exp_y, pixel_y);
		end
	valid_check: assert property (@(negedge clk) disable iff (reset) pixel_valid == exp_valid)
		else
		begin
			errors++;
			$display("FAIL pixel_valid expected %h got %h", exp_valid, pixel_valid);
		end
	color_check: assert property (@(negedge clk) disable iff (reset || !check_pixels)
		pixel_valid |-> color_index == exp_color)
		else
		begin
			errors++;
			$display("FAIL color_index expected %h got %h", exp_color, color_index);
		end
	blue_check: assert property (@(negedge clk) disable iff (reset) blocked_blue == blue_next)
		else
		begin
			errors++;
			$display("FAIL blocked_blue expected %h got %h", blue_next, blocked_blue);
		end
	red_check: assert property (@(negedge clk) disable iff (reset) blocked_red == red_next)
		else
		begin
			errors++;
			$display("FAIL blocked_red expected %h got %h", red_next, blocked_red);
		end

	task automatic write_word(input logic [ADDR_W-1:0] address, input logic [WORD_W-1:0] data);
		@(posedge clk);
		we <= 1'b1;
		write_address <= address;
		write_data <= data;
	endtask

	task automatic end_writes();
		@(posedge clk);
		we <= 1'b0;
	endtask

	// read-modify-write of one nibble
	task automatic write_pixel(input int x, input int y, input color_t nibble);
		logic [ADDR_W-1:0] address;
		logic [WORD_W-1:0] word;
		// model copy is settled on the falling edge
		@(negedge clk);
		address = ADDR_W'(y * (H_ACTIVE / 2) + x / 2);
		word = model_mem[address];
		if (x % 2 == 1)
			word[11:8] = nibble;
		else
			word[3:0] = nibble;
		write_word(address, word);
		end_writes();
	endtask

	// returns on the rising edge that starts an output row
	task automatic wait_output_row(input int row);
		do
			@(posedge clk);
		while (!(pixel_y == COORD_W'(row) && pixel_x == '0));
	endtask

	task automatic place_bikes(input int bx, input int by, input dir_t bdir,
		input int rx, input int ry, input dir_t rdir);
		blue_x <= COORD_W'(bx);
		blue_y <= COORD_W'(by);
		blue_dir <= bdir;
		red_x <= COORD_W'(rx);
		red_y <= COORD_W'(ry);
		red_dir <= rdir;
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
		begin
			$display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial
	begin
		reset = 1'b1;
		we = 1'b0;
		write_address = '0;
		write_data = '0;
		blue_x = OFF_SCREEN;
		blue_y = OFF_SCREEN;
		blue_dir = DIR_UP;
		red_x = OFF_SCREEN;
		red_y = OFF_SCREEN;
		red_dir = DIR_UP;
		check_pixels = 1'b0;
		rng = 32'hf19f0c73;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// random background
		for (int i = 0; i < DEPTH; i++)
		begin
			rng = lcg_next(rng);
			write_word(ADDR_W'(i), rng[31:16]);
		end
		end_writes();
		// bikes parked over a plain background frame
		wait_output_row(V_ACTIVE + 1);
		check_pixels <= 1'b1;
		// vertical bikes with the red nose below the screen
		wait_output_row(V_ACTIVE + 1);
		write_pixel(6, 2, 4'h5);
		place_bikes(2, 3, DIR_UP, 20, 0, DIR_DOWN);
		// overlapping horizontal bikes with the blue nose on free track
		wait_output_row(V_ACTIVE + 1);
		write_pixel(9, 8, COLOR_EMPTY);
		write_pixel(20, 10, 4'h3);
		place_bikes(10, 4, DIR_LEFT, 4, 6, DIR_RIGHT);
		wait_output_row(V_ACTIVE + 1);
		write_pixel(4, 7, 4'hc);
		place_bikes(24, 0, DIR_DOWN, 0, 8, DIR_UP);
		// row 3 already shown so the new nibble appears next frame
		wait_output_row(10);
		write_pixel(13, 3, ~bg_nibble(10'd13, 10'd3));
		wait_output_row(V_ACTIVE + 1);
		place_bikes(OFF_SCREEN, OFF_SCREEN, DIR_UP, OFF_SCREEN, OFF_SCREEN, DIR_UP);
		wait_output_row(V_ACTIVE + 1);
		$display("run complete: %0d model errors, %0d protocol errors", errors,
			uut.checks.fail_count);
		if (errors == 0 && uut.checks.fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tron_video_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module tron_video_asserts import tron_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
)
(
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input logic [3:0] color_index,
	input logic [COORD_W-1:0] pixel_x,
	input logic [COORD_W-1:0] pixel_y,
	input logic hsync,
	input logic vsync,
	input logic blocked_blue,
	input logic blocked_red
);

	// read by the testbench at the end of the run
	int fail_count = 0;

	// outputs idle while reset is held
	reset_idle: assert property (@(negedge clk) reset |->
		(!pixel_valid && color_index == '0 && !blocked_blue && !blocked_red && hsync && vsync))
		else
		begin
			fail_count++;
			$error("outputs not idle during reset");
		end

	// valid pixels only inside the visible area
	valid_in_area: assert property (@(negedge clk) disable iff (reset)
		pixel_valid |-> (pixel_x < COORD_W'(H_ACTIVE) && pixel_y < COORD_W'(V_ACTIVE)))
		else
		begin
			fail_count++;
			$error("pixel_valid high outside the visible area");
		end

	// active low syncs stay idle over visible pixels
	sync_idle: assert property (@(negedge clk) disable iff (reset)
		pixel_valid |-> (hsync && vsync))
		else
		begin
			fail_count++;
			$error("sync pulse during a valid pixel");
		end

	// flags only drop at the first pixel of a frame
	flag_hold: assert property (@(negedge clk) disable iff (reset)
		($fell(blocked_blue) || $fell(blocked_red)) |-> (pixel_x == '0 && pixel_y == '0))
		else
		begin
			fail_count++;
			$error("collision flag cleared away from the frame start");
		end

endmodule

bind tron_video_top tron_video_asserts #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) checks (
	.clk(clk), .reset(reset), .pixel_valid(pixel_valid), .color_index(color_index),
	.pixel_x(pixel_x), .pixel_y(pixel_y), .hsync(hsync), .vsync(vsync),
	.blocked_blue(blocked_blue), .blocked_red(blocked_red));

`default_nettype wire

/* logic/tron_video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tron_video_top import tron_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	parameter int H_TOTAL = 800,
	parameter int V_TOTAL = 525,
	localparam int ADDR_W = $clog2((H_ACTIVE / 2) * V_ACTIVE)
)
(
	input logic clk,
	input logic reset,
	input logic we,
	input logic [ADDR_W-1:0] write_address,
	input logic [WORD_W-1:0] write_data,
	input logic [COORD_W-1:0] blue_x,
	input logic [COORD_W-1:0] blue_y,
	input logic [1:0] blue_dir,
	input logic [COORD_W-1:0] red_x,
	input logic [COORD_W-1:0] red_y,
	input logic [1:0] red_dir,
	output logic pixel_valid,
	output logic [3:0] color_index,
	output logic [COORD_W-1:0] pixel_x,
	output logic [COORD_W-1:0] pixel_y,
	output logic hsync,
	output logic vsync,
	output logic blocked_blue,
	output logic blocked_red
);

	// shared raster position
	raster_if pos_bus ();

	// timing to pixel pipeline
	logic hsync_raw;
	logic vsync_raw;
	// frame buffer read side
	logic [ADDR_W-1:0] read_address;
	logic [WORD_W-1:0] read_data;
	// bike decisions one cycle behind the position
	color_t body_color;
	logic body_hit;
	logic blue_nose;
	logic red_nose;

	raster_timing #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL)) timing (.clk(clk), .reset(reset), .pos(pos_bus),
		.hsync(hsync_raw), .vsync(vsync_raw));

	frame_ram #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) frame_buffer (.clk(clk),
		.we(we), .write_address(write_address), .write_data(write_data),
		.read_address(read_address), .read_data(read_data));

	// heading arrives as raw bits from the game logic
	bike_raster bikes (.clk(clk), .reset(reset), .pos(pos_bus), .blue_x(blue_x),
		.blue_y(blue_y), .blue_dir(dir_t'(blue_dir)), .red_x(red_x), .red_y(red_y),
		.red_dir(dir_t'(red_dir)), .body_color(body_color), .body_hit(body_hit),
		.blue_nose(blue_nose), .red_nose(red_nose));

	pixel_combine #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) combine (.clk(clk),
		.reset(reset), .pos(pos_bus), .read_address(read_address), .read_data(read_data),
		.body_color(body_color), .body_hit(body_hit), .blue_nose(blue_nose),
		.red_nose(red_nose), .hsync_in(hsync_raw), .vsync_in(vsync_raw),
		.pixel_valid(pixel_valid), .color_index(color_index), .pixel_x(pixel_x),
		.pixel_y(pixel_y), .hsync(hsync), .vsync(vsync), .blocked_blue(blocked_blue),
		.blocked_red(blocked_red));

endmodule

`default_nettype wire

/* logic/pixel_combine.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_combine import tron_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	localparam int ADDR_W = $clog2((H_ACTIVE / 2) * V_ACTIVE)
)
(
	input logic clk,
	input logic reset,
	raster_if.sink pos,
	output logic [ADDR_W-1:0] read_address,
	input logic [WORD_W-1:0] read_data,
	input color_t body_color,
	input logic body_hit,
	input logic blue_nose,
	input logic red_nose,
	input logic hsync_in,
	input logic vsync_in,
	output logic pixel_valid,
	output color_t color_index,
	output logic [COORD_W-1:0] pixel_x,
	output logic [COORD_W-1:0] pixel_y,
	output logic hsync,
	output logic vsync,
	output logic blocked_blue,
	output logic blocked_red
);

	// stage 1 lines up with the RAM read latency
	logic active_d;
	logic frame_start_d;
	logic hsync_d;
	logic vsync_d;
	logic odd_d;
	logic [COORD_W-1:0] x_d;
	logic [COORD_W-1:0] y_d;

	color_t nibble;
	logic obstacle;

	// word address y * (H_ACTIVE/2) + x/2
	// parked at 0 during blanking
	assign read_address = pos.active ?
		ADDR_W'(pos.draw_y) * ADDR_W'(H_ACTIVE / 2) + ADDR_W'(pos.draw_x >> 1) : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active_d <= 1'b0;
			frame_start_d <= 1'b0;
			hsync_d <= 1'b1;
			vsync_d <= 1'b1;
		end
		else
		begin
			active_d <= pos.active;
			frame_start_d <= pos.frame_start;
			hsync_d <= hsync_in;
			vsync_d <= vsync_in;
		end
	end

	// position payload
	always_ff @(posedge clk)
	begin
		odd_d <= pos.draw_x[0];
		x_d <= pos.draw_x;
		y_d <= pos.draw_y;
	end

	// even x in bits 3:0 and odd x in bits 11:8
	assign nibble = odd_d ? read_data[11:8] : read_data[3:0];
	// only visible noses count
	assign obstacle = active_d && (nibble != COLOR_EMPTY);

	// stage 2 output registers and collision latches
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pixel_valid <= 1'b0;
			color_index <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			blocked_blue <= 1'b0;
			blocked_red <= 1'b0;
		end
		else
		begin
			pixel_valid <= active_d;
			// bike overlay on the background with blank pixels forced to zero
			if (!active_d)
				color_index <= '0;
			else
				color_index <= body_hit ? body_color : nibble;
			hsync <= hsync_d;
			vsync <= vsync_d;
			// set wins over the frame-start clear
			if (blue_nose && obstacle)
				blocked_blue <= 1'b1;
			else if (frame_start_d)
				blocked_blue <= 1'b0;
			if (red_nose && obstacle)
				blocked_red <= 1'b1;
			else if (frame_start_d)
				blocked_red <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		pixel_x <= x_d;
		pixel_y <= y_d;
	end

endmodule

`default_nettype wire

/* logic/bike_raster.sv */
`timescale 1ns/1ps
`default_nettype none

module bike_raster import tron_pkg::*;
(
	input logic clk,
	input logic reset,
	raster_if.sink pos,
	input logic [COORD_W-1:0] blue_x,
	input logic [COORD_W-1:0] blue_y,
	input dir_t blue_dir,
	input logic [COORD_W-1:0] red_x,
	input logic [COORD_W-1:0] red_y,
	input dir_t red_dir,
	output color_t body_color,
	output logic body_hit,
	output logic blue_nose,
	output logic red_nose
);

	// wrap-around subtraction rejects pixels left of or above the corner
	function automatic logic body_cover(
		input logic [COORD_W-1:0] px,
		input logic [COORD_W-1:0] py,
		input logic [COORD_W-1:0] bx,
		input logic [COORD_W-1:0] by,
		input dir_t dir
	);
		logic [COORD_W-1:0] dx;
		logic [COORD_W-1:0] dy;
		logic vertical;
		dx = px - bx;
		dy = py - by;
		// long side follows the heading
		vertical = (dir == DIR_UP) || (dir == DIR_DOWN);
		if (vertical)
			return (dx < BIKE_WIDTH) && (dy < BIKE_LEN);
		return (dx < BIKE_LEN) && (dy < BIKE_WIDTH);
	endfunction

	// nose pixel one step past the front edge
	function automatic logic nose_at(
		input logic [COORD_W-1:0] px,
		input logic [COORD_W-1:0] py,
		input logic [COORD_W-1:0] bx,
		input logic [COORD_W-1:0] by,
		input dir_t dir
	);
		logic [COORD_W-1:0] nx;
		logic [COORD_W-1:0] ny;
		case (dir)
			DIR_UP:
			begin
				nx = bx + NOSE_SIDE;
				ny = by - COORD_W'(1);
			end
			DIR_DOWN:
			begin
				nx = bx + NOSE_SIDE;
				ny = by + BIKE_LEN;
			end
			DIR_LEFT:
			begin
				nx = bx - COORD_W'(1);
				ny = by + NOSE_SIDE;
			end
			default:
			begin
				nx = bx + BIKE_LEN;
				ny = by + NOSE_SIDE;
			end
		endcase
		return (px == nx) && (py == ny);
	endfunction

	logic blue_cover;
	logic red_cover;

	assign blue_cover = body_cover(pos.draw_x, pos.draw_y, blue_x, blue_y, blue_dir);
	assign red_cover = body_cover(pos.draw_x, pos.draw_y, red_x, red_y, red_dir);

	// one cycle behind the position to line up with the RAM read data
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			body_color <= '0;
			body_hit <= 1'b0;
			blue_nose <= 1'b0;
			red_nose <= 1'b0;
		end
		else
		begin
			// blue drawn on top where bodies overlap
			body_color <= blue_cover ? COLOR_BLUE : COLOR_RED;
			body_hit <= blue_cover || red_cover;
			blue_nose <= nose_at(pos.draw_x, pos.draw_y, blue_x, blue_y, blue_dir);
			red_nose <= nose_at(pos.draw_x, pos.draw_y, red_x, red_y, red_dir);
		end
	end

endmodule

`default_nettype wire

/* logic/frame_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_ram import tron_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	localparam int DEPTH = (H_ACTIVE / 2) * V_ACTIVE,
	localparam int ADDR_W = $clog2(DEPTH)
)
(
	input logic clk,
	input logic we,
	input logic [ADDR_W-1:0] write_address,
	input logic [WORD_W-1:0] write_data,
	input logic [ADDR_W-1:0] read_address,
	output logic [WORD_W-1:0] read_data
);

	// two pixels per word
	logic [WORD_W-1:0] mem [DEPTH];

	// write port
	always_ff @(posedge clk)
	begin
		if (we)
			mem[write_address] <= write_data;
	end

	// registered read with data one cycle after the address
	// same-address collision returns the old word
	always_ff @(posedge clk)
	begin
		read_data <= mem[read_address];
	end

endmodule

`default_nettype wire

/* logic/raster_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_timing import tron_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	parameter int H_TOTAL = 800,
	parameter int V_TOTAL = 525
)
(
	input logic clk,
	input logic reset,
	raster_if.source pos,
	output logic hsync,
	output logic vsync
);

	// sync pulse sits in the middle half of each blanking gap
	localparam int H_SYNC_START = H_ACTIVE + (H_TOTAL - H_ACTIVE) / 4;
	localparam int H_SYNC_END = H_SYNC_START + (H_TOTAL - H_ACTIVE) / 2;
	localparam int V_SYNC_START = V_ACTIVE + (V_TOTAL - V_ACTIVE) / 4;
	localparam int V_SYNC_END = V_SYNC_START + (V_TOTAL - V_ACTIVE) / 2;

	logic [COORD_W-1:0] h_count;
	logic [COORD_W-1:0] v_count;

	// column counter wraps at H_TOTAL and the row steps on each wrap
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			h_count <= '0;
			v_count <= '0;
		end
		else if (h_count == COORD_W'(H_TOTAL - 1))
		begin
			h_count <= '0;
			// last row of the frame
			if (v_count == COORD_W'(V_TOTAL - 1))
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end
		else
			h_count <= h_count + 1'b1;
	end

	// position goes straight out of the counter registers
	assign pos.draw_x = h_count;
	assign pos.draw_y = v_count;
	assign pos.active = (h_count < COORD_W'(H_ACTIVE)) && (v_count < COORD_W'(V_ACTIVE));
	assign pos.frame_start = (h_count == '0) && (v_count == '0);

	// active low syncs aligned with the position
	assign hsync = !((h_count >= COORD_W'(H_SYNC_START)) && (h_count < COORD_W'(H_SYNC_END)));
	assign vsync = !((v_count >= COORD_W'(V_SYNC_START)) && (v_count < COORD_W'(V_SYNC_END)));

endmodule

`default_nettype wire

/* logic/raster_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface raster_if import tron_pkg::*; ();

	// current beam position
	logic [COORD_W-1:0] draw_x;
	logic [COORD_W-1:0] draw_y;
	// position lies in the visible area
	logic active;
	// single pulse at (0,0)
	logic frame_start;

	// driven by the timing generator
	modport source (output draw_x, output draw_y, output active, output frame_start);

	// read by the pixel pipeline blocks
	modport sink (input draw_x, input draw_y, input active, input frame_start);

endinterface

`default_nettype wire

/* logic/tron_pkg.sv */
`default_nettype none

package tron_pkg;

	// coordinate and frame buffer word widths
	localparam int COORD_W = 10;
	localparam int WORD_W = 16;

	// bike heading as the game logic encodes it
	typedef enum logic [1:0]
	{
		DIR_UP,
		DIR_DOWN,
		DIR_LEFT,
		DIR_RIGHT
	} dir_t;

	// 4-bit palette index
	typedef logic [3:0] color_t;

	// free track where anything else counts as an obstacle
	localparam color_t COLOR_EMPTY = 4'd8;
	// bike body colours
	localparam color_t COLOR_BLUE = 4'd1;
	localparam color_t COLOR_RED = 4'd2;

	// box size along the heading
	localparam logic [COORD_W-1:0] BIKE_LEN = 10'd16;
	// box size across the heading
	localparam logic [COORD_W-1:0] BIKE_WIDTH = 10'd8;
	// nose offset across the heading from the box corner
	localparam logic [COORD_W-1:0] NOSE_SIDE = 10'd4;

endpackage

`default_nettype wire
